// ==== hdl/bpu_pkg.sv ====
package bpu_pkg;

    // Instruction address, byte granular
    typedef logic [31:0] addr_t;

    // Fall-through step of a fixed-width 32-bit instruction
    localparam addr_t INSTR_BYTES = 32'd4;

    // Counter states in increasing confidence of taken
    // MSB is the taken prediction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_state_e;

    // Fetch-side lookup request
    typedef struct packed {
        logic  valid;
        addr_t pc;
    } lookup_req_t;

    // Resolved branch from the execute stage
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;     // Actual outcome
        addr_t target;    // Actual target, used only when taken
    } update_t;

    // Answer to a lookup, one cycle after the request
    typedef struct packed {
        logic  valid;
        logic  taken;
        logic  hit;       // BTB knew the PC
        addr_t next_pc;
    } prediction_t;

endpackage

// ==== hdl/btb.sv ====
`timescale 1ns/10ps

module btb #(
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  bpu_pkg::lookup_req_t lookup,
    input  bpu_pkg::update_t     update,
    output logic                 hit,
    output bpu_pkg::addr_t       target
);

    localparam int ENTRIES  = 1 << BTB_INDEX_BITS;
    localparam int TAG_BITS = 30 - BTB_INDEX_BITS;  // PC bits above index, 1:0 dropped
    localparam int TAG_LSB  = BTB_INDEX_BITS + 2;

    typedef logic [BTB_INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]       tag_t;

    // Direct-mapped storage
    logic           valid_mem [ENTRIES];
    tag_t           tag_mem   [ENTRIES];
    bpu_pkg::addr_t target_mem[ENTRIES];

    index_t rd_index;
    tag_t   rd_tag;
    logic   rd_match;

    index_t wr_index;
    tag_t   wr_tag;
    logic   wr_en;

    assign rd_index = lookup.pc[TAG_LSB-1:2];
    assign rd_tag   = lookup.pc[31:TAG_LSB];

    assign wr_index = update.pc[TAG_LSB-1:2];
    assign wr_tag   = update.pc[31:TAG_LSB];
    assign wr_en    = update.valid && update.taken;  // Only taken branches allocate

    // Entry valid and tag equal; sees contents from before this edge's write
    assign rd_match = valid_mem[rd_index] && (tag_mem[rd_index] == rd_tag);

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_mem[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_mem[wr_index] <= 1'b1;
        end
    end

    // Tag and target, overwrite whatever sat in the slot
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]    <= wr_tag;
            target_mem[wr_index] <= update.target;
        end
    end

    // Read result register
    always_ff @(posedge clk) begin
        if (reset) begin
            hit <= 1'b0;
        end else if (lookup.valid) begin
            hit <= rd_match;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.valid) begin
            target <= target_mem[rd_index];
        end
    end

endmodule

// ==== hdl/bht.sv ====
`timescale 1ns/10ps

module bht #(
    parameter int BHT_INDEX_BITS = 6
) (
    input  logic                 clk,
    input  logic                 reset,
    input  bpu_pkg::lookup_req_t lookup,
    input  bpu_pkg::update_t     update,
    output bpu_pkg::ctr_state_e  counter
);

    localparam int ENTRIES = 1 << BHT_INDEX_BITS;

    typedef logic [BHT_INDEX_BITS-1:0] index_t;

    bpu_pkg::ctr_state_e ctr_mem[ENTRIES];

    index_t rd_index;
    index_t wr_index;

    assign rd_index = lookup.pc[BHT_INDEX_BITS+1:2];
    assign wr_index = update.pc[BHT_INDEX_BITS+1:2];

    // One step toward the outcome, saturating at both ends
    function automatic bpu_pkg::ctr_state_e next_state(
        input bpu_pkg::ctr_state_e cur,
        input logic                taken
    );
        bpu_pkg::ctr_state_e nxt;
        nxt = cur;
        case (cur)
            bpu_pkg::STRONG_NT: begin
                if (taken) begin
                    nxt = bpu_pkg::WEAK_NT;
                end else begin
                    nxt = bpu_pkg::STRONG_NT;
                end
            end
            bpu_pkg::WEAK_NT: begin
                if (taken) begin
                    nxt = bpu_pkg::WEAK_T;
                end else begin
                    nxt = bpu_pkg::STRONG_NT;
                end
            end
            bpu_pkg::WEAK_T: begin
                if (taken) begin
                    nxt = bpu_pkg::STRONG_T;
                end else begin
                    nxt = bpu_pkg::WEAK_NT;
                end
            end
            bpu_pkg::STRONG_T: begin
                if (taken) begin
                    nxt = bpu_pkg::STRONG_T;  // Saturate
                end else begin
                    nxt = bpu_pkg::WEAK_T;
                end
            end
            default: nxt = bpu_pkg::STRONG_NT;
        endcase
        return nxt;
    endfunction

    // Counter table
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_mem[i] <= bpu_pkg::STRONG_NT;
            end
        end else if (update.valid) begin
            ctr_mem[wr_index] <= next_state(ctr_mem[wr_index], update.taken);
        end
    end

    // Registered read, old value on a same-edge update
    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= bpu_pkg::STRONG_NT;
        end else if (lookup.valid) begin
            counter <= ctr_mem[rd_index];
        end
    end

endmodule

// ==== hdl/bpu.sv ====
`timescale 1ns/10ps

module bpu #(
    parameter int BHT_INDEX_BITS = 6,
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  bpu_pkg::lookup_req_t lookup,
    input  bpu_pkg::update_t     update,
    output bpu_pkg::prediction_t prediction
);

    // Request being answered this cycle
    logic           req_valid_q;
    bpu_pkg::addr_t req_pc_q;
    bpu_pkg::addr_t fall_through;

    // Table outputs, aligned with the request registers
    logic                btb_hit;
    bpu_pkg::addr_t      btb_target;
    bpu_pkg::ctr_state_e bht_counter;

    logic predict_taken;

    btb #(
        .BTB_INDEX_BITS(BTB_INDEX_BITS)
    ) btb_inst (
        .clk   (clk),
        .reset (reset),
        .lookup(lookup),
        .update(update),
        .hit   (btb_hit),
        .target(btb_target)
    );

    bht #(
        .BHT_INDEX_BITS(BHT_INDEX_BITS)
    ) bht_inst (
        .clk    (clk),
        .reset  (reset),
        .lookup (lookup),
        .update (update),
        .counter(bht_counter)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= lookup.valid;  // One-cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.valid) begin
            req_pc_q <= lookup.pc;
        end
    end

    assign fall_through = req_pc_q + bpu_pkg::INSTR_BYTES;

    // Counter alone cannot redirect without a known target
    assign predict_taken = btb_hit && bht_counter[1];

    always_comb begin
        prediction.valid = req_valid_q;
        prediction.hit   = btb_hit;
        prediction.taken = predict_taken;
        if (predict_taken) begin
            prediction.next_pc = btb_target;
        end else begin
            prediction.next_pc = fall_through;
        end
    end

endmodule

// ==== bench/bpu_tb.sv ====
`timescale 1ns/10ps

module bpu_tb;

    localparam int BHT_INDEX_BITS = 6;
    localparam int BTB_INDEX_BITS = 4;
    localparam int RESULT_TIMEOUT = 4;  // Cycles to wait for prediction.valid
    localparam int COLD_LOOKUPS   = 3;

    // A and B share the BTB and BHT index but differ in tag
    localparam bpu_pkg::addr_t PC_A  = 32'h0000_1040;
    localparam bpu_pkg::addr_t PC_B  = 32'h0000_1140;
    localparam bpu_pkg::addr_t PC_C  = 32'h0000_2208;
    localparam bpu_pkg::addr_t PC_D  = 32'h0000_3314;
    localparam bpu_pkg::addr_t TGT_A = 32'h0000_2000;
    localparam bpu_pkg::addr_t TGT_B = 32'h0000_3000;
    localparam bpu_pkg::addr_t TGT_C = 32'h0000_4000;
    localparam bpu_pkg::addr_t TGT_D = 32'h0000_5000;

    // One stimulus row with its expected answer
    typedef struct packed {
        bpu_pkg::update_t     upd;
        bpu_pkg::lookup_req_t lkp;
        logic                 exp_taken;
        logic                 exp_hit;
        bpu_pkg::addr_t       exp_next_pc;
    } row_t;

    logic                 clk;
    logic                 reset;
    bpu_pkg::lookup_req_t lookup;
    bpu_pkg::update_t     update;
    bpu_pkg::prediction_t prediction;

    row_t        rows[$];
    string       row_names[$];
    logic [31:0] rng_state;
    int          tests_run;
    int          tests_failed;

    bpu #(
        .BHT_INDEX_BITS(BHT_INDEX_BITS),
        .BTB_INDEX_BITS(BTB_INDEX_BITS)
    ) bpu_inst (
        .clk       (clk),
        .reset     (reset),
        .lookup    (lookup),
        .update    (update),
        .prediction(prediction)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bpu_pkg::update_t make_update(
        input bpu_pkg::addr_t pc,
        input logic           taken,
        input bpu_pkg::addr_t target
    );
        bpu_pkg::update_t u;
        u.valid  = 1'b1;
        u.pc     = pc;
        u.taken  = taken;
        u.target = target;
        return u;
    endfunction

    function automatic bpu_pkg::update_t no_update();
        bpu_pkg::update_t u;
        u = '0;
        return u;
    endfunction

    function automatic bpu_pkg::lookup_req_t make_lookup(input bpu_pkg::addr_t pc);
        bpu_pkg::lookup_req_t l;
        l.valid = 1'b1;
        l.pc    = pc;
        return l;
    endfunction

    function automatic bpu_pkg::lookup_req_t no_lookup();
        bpu_pkg::lookup_req_t l;
        l = '0;
        return l;
    endfunction

    task automatic add_row(
        input string                name,
        input bpu_pkg::update_t     upd,
        input bpu_pkg::lookup_req_t lkp,
        input logic                 exp_taken,
        input logic                 exp_hit,
        input bpu_pkg::addr_t       exp_next_pc
    );
        row_t r;
        r.upd         = upd;
        r.lkp         = lkp;
        r.exp_taken   = exp_taken;
        r.exp_hit     = exp_hit;
        r.exp_next_pc = exp_next_pc;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    task automatic idle_inputs();
        lookup = '0;
        update = '0;
    endtask

    // Counter of A/B index noted after each update row
    task automatic build_table();
        bpu_pkg::addr_t pc;
        for (int i = 0; i < COLD_LOOKUPS; i++) begin
            rng_state = lcg_next(rng_state);
            pc = rng_state & 32'hFFFF_FFFC;
            add_row($sformatf("cold_miss_%0d", i), no_update(), make_lookup(pc),
                    1'b0, 1'b0, pc + 32'd4);
        end
        add_row("alloc_update", make_update(PC_A, 1'b1, TGT_A), no_lookup(),
                1'b0, 1'b0, '0);  // WEAK_NT
        add_row("alloc_lookup", no_update(), make_lookup(PC_A), 1'b0, 1'b1, PC_A + 32'd4);
        add_row("learn_update", make_update(PC_A, 1'b1, TGT_A), no_lookup(),
                1'b0, 1'b0, '0);  // WEAK_T
        add_row("learn_lookup", no_update(), make_lookup(PC_A), 1'b1, 1'b1, TGT_A);
        add_row("sat_update_1", make_update(PC_A, 1'b1, TGT_A), no_lookup(),
                1'b0, 1'b0, '0);  // STRONG_T
        add_row("sat_update_2", make_update(PC_A, 1'b1, TGT_A), no_lookup(),
                1'b0, 1'b0, '0);  // Stays STRONG_T
        add_row("sat_lookup", no_update(), make_lookup(PC_A), 1'b1, 1'b1, TGT_A);
        add_row("hyst_nt_1", make_update(PC_A, 1'b0, '0), no_lookup(),
                1'b0, 1'b0, '0);  // WEAK_T
        add_row("hyst_lookup_1", no_update(), make_lookup(PC_A), 1'b1, 1'b1, TGT_A);
        add_row("hyst_nt_2", make_update(PC_A, 1'b0, '0), no_lookup(),
                1'b0, 1'b0, '0);  // WEAK_NT
        add_row("hyst_lookup_2", no_update(), make_lookup(PC_A), 1'b0, 1'b1, PC_A + 32'd4);
        for (int i = 0; i < 4; i++) begin
            add_row($sformatf("floor_nt_%0d", i), make_update(PC_A, 1'b0, '0), no_lookup(),
                    1'b0, 1'b0, '0);  // Ends at STRONG_NT
        end
        add_row("floor_taken", make_update(PC_A, 1'b1, TGT_A), no_lookup(),
                1'b0, 1'b0, '0);  // WEAK_NT
        add_row("floor_lookup", no_update(), make_lookup(PC_A), 1'b0, 1'b1, PC_A + 32'd4);
        // Tag conflict on the shared index
        add_row("conflict_lookup_b", no_update(), make_lookup(PC_B),
                1'b0, 1'b0, PC_B + 32'd4);
        add_row("conflict_update_b", make_update(PC_B, 1'b1, TGT_B), no_lookup(),
                1'b0, 1'b0, '0);  // WEAK_T and the entry now holds B
        add_row("conflict_lookup_a", no_update(), make_lookup(PC_A),
                1'b0, 1'b0, PC_A + 32'd4);
        add_row("conflict_hit_b", no_update(), make_lookup(PC_B), 1'b1, 1'b1, TGT_B);
        // Update and lookup sampled at the same edge
        add_row("order_prep_1", make_update(PC_C, 1'b1, TGT_C), no_lookup(),
                1'b0, 1'b0, '0);
        add_row("order_prep_2", make_update(PC_C, 1'b1, TGT_C), no_lookup(),
                1'b0, 1'b0, '0);  // C at WEAK_T
        add_row("order_same_c", make_update(PC_C, 1'b0, '0), make_lookup(PC_C),
                1'b1, 1'b1, TGT_C);
        add_row("order_after_c", no_update(), make_lookup(PC_C), 1'b0, 1'b1, PC_C + 32'd4);
        add_row("order_alloc_d", make_update(PC_D, 1'b1, TGT_D), make_lookup(PC_D),
                1'b0, 1'b0, PC_D + 32'd4);
        add_row("order_after_d", no_update(), make_lookup(PC_D), 1'b0, 1'b1, PC_D + 32'd4);
    endtask

    task automatic apply_row(input int idx);
        row_t  r;
        string name;
        int    waited;
        logic  seen;
        int    errors;
        r      = rows[idx];
        name   = row_names[idx];
        waited = 0;
        seen   = 1'b0;
        errors = 0;
        lookup = r.lkp;
        update = r.upd;
        if (!r.lkp.valid) begin
            @(negedge clk);
            idle_inputs();
            if (prediction.valid !== 1'b0) begin  // No lookup, no strobe
                $display("Fail %s valid: expected 0, actual %b", name, prediction.valid);
                errors++;
            end
        end else begin
            while (!seen && waited < RESULT_TIMEOUT) begin
                @(negedge clk);
                idle_inputs();
                waited++;
                if (prediction.valid === 1'b1) begin
                    seen = 1'b1;
                end
            end
            if (!seen) begin
                $display("Error %s: no valid prediction within %0d cycles",
                         name, RESULT_TIMEOUT);
                errors++;
            end else begin
                if (waited != 1) begin
                    $display("Fail %s latency: expected 1, actual %0d", name, waited);
                    errors++;
                end
                if (prediction.hit !== r.exp_hit) begin
                    $display("Fail %s hit: expected %b, actual %b",
                             name, r.exp_hit, prediction.hit);
                    errors++;
                end
                if (prediction.taken !== r.exp_taken) begin
                    $display("Fail %s taken: expected %b, actual %b",
                             name, r.exp_taken, prediction.taken);
                    errors++;
                end
                if (prediction.next_pc !== r.exp_next_pc) begin
                    $display("Fail %s next_pc: expected %h, actual %h",
                             name, r.exp_next_pc, prediction.next_pc);
                    errors++;
                end
            end
        end
        tests_run++;
        if (errors == 0) begin
            $display("Pass %s", name);
        end else begin
            tests_failed++;
        end
    endtask

    initial begin
        reset        = 1'b1;
        lookup       = make_lookup(PC_A);  // Request held during reset
        update       = '0;
        rng_state    = 32'd1;
        tests_run    = 0;
        tests_failed = 0;
        build_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idle_inputs();

        tests_run++;
        if (prediction.valid !== 1'b0) begin
            $display("Fail reset_idle valid: expected 0, actual %b", prediction.valid);
            tests_failed++;
        end else begin
            $display("Pass reset_idle");
        end

        // One row per cycle on the falling edge
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== bpu.f ====
hdl/bpu_pkg.sv
hdl/btb.sv
hdl/bht.sv
hdl/bpu.sv
bench/bpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the branch predictor testbench with Verilator and run it.
# The exit status is nonzero when the testbench reports a failure.
set -e
set -o pipefail 2>/dev/null || true

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
    --top-module bpu_tb \
    -f bpu.f \
    -o bpu_sim

./obj_dir/bpu_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0
